//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module acq_tb -Mdir obj_dir -f verilog.f

run: compile
	@out=$$(./obj_dir/Vacq_tb 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir

//--- verification/acq_tb.sv
module acq_tb import acq_pkg::*; ();

    // Every source cuts its stream into packets of this many beats
    localparam int PKT_LEN = 4;
    localparam int RESET_CYCLES = 8;
    // Beats the sources are set up to send over the whole run
    // Channels 0, 1, 3 and 5 get a target of 8, channel 2 of 16 and channel 4 of 34
    localparam int TOTAL_BEATS = 82;
    // Random ready can stretch a transfer over several cycles
    localparam int STALL_FACTOR = 4;
    localparam int CYCLE_LIMIT = 2 * TOTAL_BEATS * STALL_FACTOR + RESET_CYCLES;

    logic                    clock = 1'b0;
    logic                    rst_n;
    logic [SELECT_WIDTH-1:0] selector;
    stream_beat_t            in_beat [N_CHANNELS] = '{default: '0};
    logic [N_CHANNELS-1:0]   in_valid = '0;
    logic [N_CHANNELS-1:0]   in_ready;
    stream_beat_t            out_beat;
    logic                    out_valid;
    logic                    out_ready = 1'b1;

    // In the source model seq counts accepted beats and target is where a source stops
    int                    seq [N_CHANNELS];
    int                    target [N_CHANNELS];
    logic [N_CHANNELS-1:0] fire;
    // Beats accepted by each channel and not yet seen at the output
    stream_beat_t          acc_q [N_CHANNELS][$];

    // Downstream ready control
    logic hold_ready;
    logic random_ready;
    int   seed;

    // The scoreboard's view of the active channel switches only at packet ends
    int    exp_ch;
    int    pend_ch;
    logic  pend_valid;
    logic  out_open;
    string test_name;
    int    cycle_count = 0;

    acq_top DUT (
        .clock     (clock),
        .rst_n     (rst_n),
        .selector  (selector),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    always #2 clock = ~clock;

    // Beat n of a channel carries the channel number in the top data byte and n below it
    // The user tag is the packet number and last marks the final beat of each packet
    function automatic stream_beat_t make_beat(input int ch, input int n);
        stream_beat_t b;
        b.data = {8'(ch), 24'(n)};
        b.dest = 16'(ch);
        b.user = 16'(n / PKT_LEN);
        b.last = (n % PKT_LEN) == (PKT_LEN - 1);
        return b;
    endfunction

    task automatic report_mismatch(input string what, input logic [64:0] expected,
                                   input logic [64:0] actual);
        $display("[FAIL] %s: expected %0h, actual %0h", what, expected, actual);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic abort_run(input string what);
        $display("Error in test %s: %s", test_name, what);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            abort_run("the run did not finish within the cycle limit");
        end
    end

    // Handshakes are sampled mid-cycle where every DUT output has settled
    // What is seen here transfers on the next rising edge
    always @(negedge clock) begin
        stream_beat_t expected;
        fire = in_valid & in_ready;
        for (int ch = 0; ch < N_CHANNELS; ch++) begin
            if (fire[ch]) begin
                acc_q[ch].push_back(make_beat(ch, seq[ch]));
            end
        end
        if (out_valid && out_ready) begin
            assert (exp_ch < N_CHANNELS)
                else abort_run("a beat reached the output while no channel was selected");
            if (exp_ch < N_CHANNELS) begin
                assert (acc_q[exp_ch].size() > 0)
                    else abort_run("a beat reached the output that no source had sent");
                expected = acc_q[exp_ch].pop_front();
                assert (out_beat == expected)
                    else report_mismatch(test_name, expected, out_beat);
                out_open = !expected.last;
                // A pending switch takes effect once the open packet has ended
                if (expected.last && pend_valid) begin
                    exp_ch = pend_ch;
                    pend_valid = 1'b0;
                end
            end
        end
    end

    // Sources and downstream ready move one unit after the rising edge
    always @(posedge clock) begin
        int rnd;
        #1;
        for (int ch = 0; ch < N_CHANNELS; ch++) begin
            if (fire[ch]) begin
                seq[ch] = seq[ch] + 1;
            end
            // A source keeps its beat stable until it is taken
            in_valid[ch] = seq[ch] < target[ch];
            in_beat[ch] = make_beat(ch, seq[ch]);
        end
        rnd = $random(seed);
        if (hold_ready) begin
            out_ready = 1'b0;
        end else if (random_ready) begin
            out_ready = rnd[0];
        end else begin
            out_ready = 1'b1;
        end
    end

    // Returns late in the cycle after the sources and the monitor have moved
    task automatic settle_cycle();
        @(posedge clock);
        #3;
    endtask

    task automatic drive_selector(input int value);
        @(posedge clock);
        #1;
        selector = SELECT_WIDTH'(value);
        // A switch requested inside an open packet waits for its last beat
        if (out_open) begin
            pend_ch = value;
            pend_valid = 1'b1;
        end else begin
            exp_ch = value;
        end
        #2;
    endtask

    // Waits until a source has sent all its beats and all of them came out
    task automatic wait_drained(input int ch);
        while (seq[ch] < target[ch] || acc_q[ch].size() != 0) begin
            settle_cycle();
        end
    endtask

    function automatic int accepted_total();
        int sum;
        sum = 0;
        for (int ch = 0; ch < N_CHANNELS; ch++) begin
            sum = sum + seq[ch];
        end
        return sum;
    endfunction

    task automatic check_reset_state();
        test_name = "reset_state";
        // The last of the rising edges under reset comes before the release below
        for (int i = 0; i < RESET_CYCLES - 1; i++) begin
            settle_cycle();
            assert (out_valid == 1'b0) else report_mismatch(test_name, 0, out_valid);
            assert (in_ready == '1)
                else report_mismatch(test_name, {N_CHANNELS{1'b1}}, in_ready);
        end
        @(posedge clock);
        #1;
        rst_n = 1'b1;
        #2;
        assert (out_valid == 1'b0) else report_mismatch(test_name, 0, out_valid);
        assert (in_ready == '1)
            else report_mismatch(test_name, {N_CHANNELS{1'b1}}, in_ready);
        // Sources offer three beats each but nothing is selected
        for (int ch = 0; ch < N_CHANNELS; ch++) begin
            target[ch] = 3;
        end
        repeat (20) settle_cycle();
        // Each buffer holds two beats and then refuses the third
        assert (in_ready == '0) else report_mismatch(test_name, 0, in_ready);
        for (int ch = 0; ch < N_CHANNELS; ch++) begin
            assert (acc_q[ch].size() == 2)
                else report_mismatch({test_name, " buffered"}, 2, acc_q[ch].size());
        end
    endtask

    task automatic run_single_channel();
        test_name = "single_channel";
        drive_selector(2);
        for (int ch = 0; ch < N_CHANNELS; ch++) begin
            target[ch] = 8;
        end
        // Channel 1 stops inside its first packet for the next test
        target[1] = 3;
        target[2] = 12;
        wait_drained(2);
    endtask

    task automatic switch_mid_packet();
        test_name = "packet_switch";
        drive_selector(1);
        wait_drained(1);
        // Beat 2 of channel 1 has passed and its packet is still open
        drive_selector(4);
        target[1] = 8;
        wait_drained(4);
        // Only the rest of the open packet may pass so the next one stays buffered
        assert (acc_q[1].size() == 2)
            else report_mismatch({test_name, " held"}, 2, acc_q[1].size());
    endtask

    task automatic apply_backpressure();
        int start;
        int accepted;
        test_name = "backpressure";
        start = seq[4];
        hold_ready = 1'b1;
        target[4] = 28;
        settle_cycle();
        while (in_ready[4]) begin
            settle_cycle();
        end
        // The FIFO and the two buffer entries are all that can absorb the stall
        accepted = seq[4] - start;
        assert (accepted <= FIFO_DEPTH + 2)
            else report_mismatch({test_name, " accepted"}, FIFO_DEPTH + 2, accepted);
        repeat (4) settle_cycle();
        assert (seq[4] - start == accepted)
            else report_mismatch({test_name, " stalled"}, accepted, seq[4] - start);
        hold_ready = 1'b0;
        random_ready = 1'b1;
        wait_drained(4);
        random_ready = 1'b0;
    endtask

    task automatic block_out_of_range();
        int total;
        test_name = "out_of_range";
        drive_selector(N_CHANNELS);
        target[2] = 16;
        target[4] = 34;
        settle_cycle();
        while (in_ready != '0) begin
            settle_cycle();
        end
        total = accepted_total();
        repeat (20) settle_cycle();
        assert (accepted_total() == total)
            else report_mismatch({test_name, " handshakes"}, total, accepted_total());
        // Channel 3 resumes with its two buffered beats first
        drive_selector(3);
        wait_drained(3);
    endtask

    initial begin
        rst_n = 1'b0;
        selector = SELECT_NONE;
        fire = '0;
        for (int ch = 0; ch < N_CHANNELS; ch++) begin
            seq[ch] = 0;
            target[ch] = 0;
        end
        hold_ready = 1'b0;
        random_ready = 1'b0;
        seed = 64;
        exp_ch = SELECT_NONE;
        pend_ch = 0;
        pend_valid = 1'b0;
        out_open = 1'b0;
        check_reset_state();
        run_single_channel();
        switch_mid_packet();
        apply_backpressure();
        block_out_of_range();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- verilog.f
verilog/acq_pkg.sv
verilog/channel_buffer.sv
verilog/selector_guard.sv
verilog/channel_selector.sv
verilog/stream_fifo.sv
verilog/acq_top.sv
verification/acq_tb.sv

//--- verilog/acq_pkg.sv
package acq_pkg;

    // Number of independent sample sources feeding the front end
    localparam int N_CHANNELS = 6;

    // Field widths of one stream beat
    localparam int DATA_WIDTH = 32;
    localparam int DEST_WIDTH = 16;
    localparam int USER_WIDTH = 16;

    // The selector is a full byte, wider than the channel count needs
    localparam int SELECT_WIDTH = 8;

    // All ones selects no channel at all, every source stalls
    localparam logic [SELECT_WIDTH-1:0] SELECT_NONE = '1;

    // Output FIFO geometry
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
    // One extra bit so the count can hold the full value
    localparam int FIFO_COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    // One beat of a stream, valid and ready travel beside it
    // Width is 32 + 16 + 16 + 1 = 65 bits
    typedef struct packed {
        // Sample payload
        logic [DATA_WIDTH-1:0] data;
        // Destination field, passed through untouched
        logic [DEST_WIDTH-1:0] dest;
        // User tag, passed through untouched
        logic [USER_WIDTH-1:0] user;
        // Marks the final beat of a packet
        logic                  last;
    } stream_beat_t;

endpackage

//--- verilog/acq_top.sv
module acq_top import acq_pkg::*; (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic [SELECT_WIDTH-1:0] selector,
    input  stream_beat_t            in_beat [N_CHANNELS],
    input  logic [N_CHANNELS-1:0]   in_valid,
    output logic [N_CHANNELS-1:0]   in_ready,
    output stream_beat_t            out_beat,
    output logic                    out_valid,
    input  logic                    out_ready
);

    // Buffered channel streams, one per source
    stream_beat_t          buf_beat [N_CHANNELS];
    logic [N_CHANNELS-1:0] buf_valid;
    logic [N_CHANNELS-1:0] buf_ready;

    // Selected stream heading into the output FIFO
    stream_beat_t sel_beat;
    logic         sel_valid;
    logic         sel_ready;

    // Channel select as actually applied, only moves between packets
    logic [SELECT_WIDTH-1:0] active_sel;

    // Each source gets its own buffer
    // Sources that are not selected can keep pushing until their buffer fills
    for (genvar ch = 0; ch < N_CHANNELS; ch++) begin : g_channel
        channel_buffer u_buffer (
            .clock     (clock),
            .rst_n     (rst_n),
            .in_beat   (in_beat[ch]),
            .in_valid  (in_valid[ch]),
            .in_ready  (in_ready[ch]),
            .out_beat  (buf_beat[ch]),
            .out_valid (buf_valid[ch]),
            .out_ready (buf_ready[ch])
        );
    end

    // Guard watches the selector output, that is where packets are counted
    selector_guard u_guard (
        .clock      (clock),
        .rst_n      (rst_n),
        .selector   (selector),
        .beat_valid (sel_valid),
        .beat_ready (sel_ready),
        .beat_last  (sel_beat.last),
        .active_sel (active_sel)
    );

    // Purely combinational, adds no latency
    channel_selector u_selector (
        .active_sel (active_sel),
        .in_beat    (buf_beat),
        .in_valid   (buf_valid),
        .in_ready   (buf_ready),
        .out_beat   (sel_beat),
        .out_valid  (sel_valid),
        .out_ready  (sel_ready)
    );

    // Output FIFO soaks up downstream stalls before they reach the buffers
    stream_fifo u_fifo (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_beat   (sel_beat),
        .in_valid  (sel_valid),
        .in_ready  (sel_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

//--- verilog/channel_buffer.sv
module channel_buffer import acq_pkg::*; (
    input  logic         clock,
    input  logic         rst_n,
    input  stream_beat_t in_beat,
    input  logic         in_valid,
    output logic         in_ready,
    output stream_beat_t out_beat,
    output logic         out_valid,
    input  logic         out_ready
);

    // Main register drives the output directly
    stream_beat_t main_beat;
    logic         main_valid;

    // Skid register catches the beat accepted while the main entry stalls
    stream_beat_t skid_beat;
    logic         skid_valid;

    logic in_xfer;
    logic out_xfer;

    // Ready depends only on local state, never on out_ready
    // This keeps the source off the combinational path through the shared mux
    assign in_ready  = !skid_valid;
    assign in_xfer   = in_valid & in_ready;

    assign out_valid = main_valid;
    assign out_beat  = main_beat;
    assign out_xfer  = main_valid & out_ready;

    // Occupancy flags
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            if (!main_valid || out_xfer) begin
                // Main entry is free or drains this cycle
                // A skidded beat is older than anything at the input, so it goes first
                if (skid_valid) begin
                    main_valid <= 1'b1;
                    skid_valid <= 1'b0;
                end else begin
                    main_valid <= in_xfer;
                end
            end else if (in_xfer) begin
                // Main entry is stuck, park the new beat in the skid slot
                skid_valid <= 1'b1;
            end
        end
    end

    // Payload registers follow the same decisions as the flags above
    always_ff @(posedge clock) begin
        if (!main_valid || out_xfer) begin
            if (skid_valid) begin
                main_beat <= skid_beat;
            end else if (in_xfer) begin
                main_beat <= in_beat;
            end
        end else if (in_xfer) begin
            skid_beat <= in_beat;
        end
    end

endmodule

//--- verilog/channel_selector.sv
module channel_selector import acq_pkg::*; (
    input  logic [SELECT_WIDTH-1:0] active_sel,
    input  stream_beat_t            in_beat [N_CHANNELS],
    input  logic [N_CHANNELS-1:0]   in_valid,
    output logic [N_CHANNELS-1:0]   in_ready,
    output stream_beat_t            out_beat,
    output logic                    out_valid,
    input  logic                    out_ready
);

    // One-hot view of the active select
    // Stays all zero when the select is out of range
    logic [N_CHANNELS-1:0] grant;

    always_comb begin
        grant = '0;
        for (int i = 0; i < N_CHANNELS; i++) begin
            if (active_sel == SELECT_WIDTH'(i)) begin
                grant[i] = 1'b1;
            end
        end
    end

    // Only the granted channel sees the downstream ready
    // The others hold their beats in their own buffers
    assign in_ready = grant & {N_CHANNELS{out_ready}};

    // With no grant the output is simply never valid
    assign out_valid = |(grant & in_valid);

    // Payload mux, an AND-OR over the channels
    // At most one grant bit is set, so the OR picks exactly one beat
    always_comb begin
        out_beat = '0;
        for (int i = 0; i < N_CHANNELS; i++) begin
            if (grant[i]) begin
                out_beat = out_beat | in_beat[i];
            end
        end
    end

endmodule

//--- verilog/selector_guard.sv
module selector_guard import acq_pkg::*; (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic [SELECT_WIDTH-1:0] selector,
    input  logic                    beat_valid,
    input  logic                    beat_ready,
    input  logic                    beat_last,
    output logic [SELECT_WIDTH-1:0] active_sel
);

    // Handshake seen at the output of the channel selector
    logic beat_xfer;

    // High between a transfer without last and the transfer with last
    logic packet_open;
    logic packet_open_next;

    // Selector may be loaded at this edge
    logic switch_ok;

    assign beat_xfer = beat_valid & beat_ready;

    // Packet state after the current edge
    // A beat without last opens (or keeps open) a packet, a last beat closes it
    always_comb begin
        packet_open_next = packet_open;
        if (beat_xfer) begin
            packet_open_next = !beat_last;
        end
    end

    // Looking at the next state covers two corner cases
    // A first beat moving this cycle blocks the load, a last beat moving allows it
    assign switch_ok = !packet_open_next;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            packet_open <= 1'b0;
            // Nothing passes until a channel is explicitly chosen
            active_sel  <= SELECT_NONE;
        end else begin
            packet_open <= packet_open_next;
            if (switch_ok) begin
                active_sel <= selector;
            end
        end
    end

endmodule

//--- verilog/stream_fifo.sv
module stream_fifo import acq_pkg::*; (
    input  logic         clock,
    input  logic         rst_n,
    input  stream_beat_t in_beat,
    input  logic         in_valid,
    output logic         in_ready,
    output stream_beat_t out_beat,
    output logic         out_valid,
    input  logic         out_ready
);

    // Beat storage, a circular buffer
    stream_beat_t mem [FIFO_DEPTH];

    logic [FIFO_PTR_WIDTH-1:0]   wr_ptr;
    logic [FIFO_PTR_WIDTH-1:0]   rd_ptr;
    logic [FIFO_COUNT_WIDTH-1:0] count;

    logic full;
    logic empty;
    logic wr_en;
    logic rd_en;

    // Status flags come straight from the registered count
    assign full  = (count == FIFO_COUNT_WIDTH'(FIFO_DEPTH));
    assign empty = (count == '0);

    // A full FIFO refuses writes even when a read happens in the same cycle
    assign in_ready  = !full;
    assign out_valid = !empty;
    assign out_beat  = mem[rd_ptr];

    assign wr_en = in_valid & in_ready;
    assign rd_en = out_valid & out_ready;

    // Pointers and count
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                // Explicit wrap, so a depth that is not a power of two still works
                if (wr_ptr == FIFO_PTR_WIDTH'(FIFO_DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (rd_en) begin
                if (rd_ptr == FIFO_PTR_WIDTH'(FIFO_DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            // Simultaneous read and write leave the count unchanged
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage write, the new beat is visible at the output next cycle
    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_beat;
        end
    end

endmodule
